/* rtl/ucode_format_pkg.sv */
// Microcode load file format
package ucode_format_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  localparam int WORD_BITS       = 16;
  localparam int CHAR_BITS       = 7;
  // Payload bits carried by one character
  localparam int CHAR_FIELD_BITS = 6;
  localparam int CRAM_ADDR_BITS  = 11;
  localparam int CRAM_WORD_BITS  = 86;
  localparam int DRAM_ADDR_BITS  = 9;

  // Load file words per RAM entry
  localparam int CRAM_WORDS_PER_ENTRY = 6;
  localparam int DRAM_WORDS_PER_PAIR  = 3;

  typedef logic [WORD_BITS-1:0]      word16_t;
  typedef logic [CHAR_BITS-1:0]      char_t;
  typedef logic [CRAM_ADDR_BITS-1:0] cram_addr_t;
  // Line order is 64-79, 48-63, 32-47, 16-31, 0-15, then 80-85
  typedef logic [CRAM_WORD_BITS-1:0] cram_word_t;
  typedef logic [DRAM_ADDR_BITS-1:0] dram_addr_t;

  // Record kind taken from the first character of a line
  typedef enum logic [1:0] {
    REC_SKIP = 2'd0,
    REC_CRAM = 2'd1,
    REC_DRAM = 2'd2
  } rec_type_e;

  ////////////////////
  // Character codes
  ////////////////////

  localparam char_t CHAR_COMMA = 7'h2c;
  localparam char_t CHAR_LF    = 7'h0a;
  localparam char_t CHAR_SPACE = 7'h20;
  localparam char_t CHAR_C     = 7'h43;
  localparam char_t CHAR_D     = 7'h44;

endpackage

/* rtl/diag_bus_pkg.sv */
// Diagnostic RAM write port
package diag_bus_pkg;

  // Address wide enough for the control RAM
  localparam int DIAG_ADDR_BITS = 11;
  // Data wide enough for one control word
  localparam int DIAG_DATA_BITS = 86;
  // Dispatch pair is even, odd and common words
  localparam int DRAM_PAIR_BITS = 48;

  typedef logic [DIAG_ADDR_BITS-1:0] diag_addr_t;
  typedef logic [DIAG_DATA_BITS-1:0] diag_data_t;

  // Write opcode presented with the strobe
  typedef enum logic [1:0] {
    DF_IDLE       = 2'd0,
    DF_WRITE_CRAM = 2'd1,
    DF_WRITE_DRAM = 2'd2
  } diag_func_e;

endpackage

/* rtl/fe_loader_ifs.sv */
// Loader internal buses
`timescale 1ns/1ps

// Decoded words from decoder to parser
interface word_if;
  import ucode_format_pkg::*;

  logic      valid;
  logic      ready;
  word16_t   data;
  // Marks the checksum word closing a line
  logic      last;
  rec_type_e rec_type;

  modport source (output valid, data, last, rec_type, input ready);
  modport sink   (input valid, data, last, rec_type, output ready);
endinterface

// RAM write requests from parser to sequencer
interface ram_wr_if;
  import diag_bus_pkg::*;

  logic       valid;
  logic       ready;
  diag_func_e func;
  diag_addr_t addr;
  diag_data_t data;

  modport source (output valid, func, addr, data, input ready);
  modport sink   (input valid, func, addr, data, output ready);
endinterface

// One-cycle event pulses toward the status block
interface status_ev_if;
  logic line_good;
  logic line_bad;
  logic eof_cram;
  logic eof_dram;

  modport source (output line_good, line_bad, eof_cram, eof_dram);
  modport sink   (input line_good, line_bad, eof_cram, eof_dram);
endinterface

/* rtl/asciiz_word_decoder.sv */
// Character stream to word decoder
`timescale 1ns/1ps

module asciiz_word_decoder (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    chr_valid,
  output logic                    chr_ready,
  input  ucode_format_pkg::char_t chr_data,
  word_if.source                  word_out
);
  import ucode_format_pkg::*;

  typedef enum logic [1:0] {DS_TYPE, DS_SPACE, DS_FIELD} dec_state_e;

  dec_state_e state_q;
  rec_type_e  rec_q;
  word16_t    acc_q;
  logic       take;
  logic       is_delim;
  logic       emit;
  logic       out_valid_q;
  word16_t    out_data_q;
  logic       out_last_q;
  rec_type_e  out_rec_q;

  // Stall characters while a finished word waits
  assign chr_ready = ~out_valid_q | word_out.ready;
  assign take      = chr_valid & chr_ready;
  assign is_delim  = (chr_data == CHAR_COMMA) || (chr_data == CHAR_LF);
  // Type character never closes a field
  assign emit      = take & is_delim & (state_q != DS_TYPE);

  ////////////////////
  // Line tracking
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DS_TYPE;
      rec_q   <= REC_SKIP;
      acc_q   <= '0;
    end else if (take) begin
      if (state_q == DS_TYPE) begin
        // Blank lines are ignored
        if (chr_data != CHAR_LF) begin
          if (chr_data == CHAR_C) rec_q <= REC_CRAM;
          else if (chr_data == CHAR_D) rec_q <= REC_DRAM;
          else rec_q <= REC_SKIP;
          state_q <= DS_SPACE;
        end
      end else if (state_q == DS_SPACE && chr_data == CHAR_SPACE) begin
        state_q <= DS_FIELD;
      end else if (is_delim) begin
        acc_q   <= '0;
        state_q <= (chr_data == CHAR_LF) ? DS_TYPE : DS_FIELD;
      end else begin
        // Six new low bits, older bits move up
        acc_q   <= (acc_q << CHAR_FIELD_BITS) | word16_t'(chr_data[CHAR_FIELD_BITS-1:0]);
        state_q <= DS_FIELD;
      end
    end
  end

  ////////////////////
  // Word output
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (emit) begin
      out_valid_q <= 1'b1;
    end else if (word_out.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      out_data_q <= acc_q;
      out_last_q <= (chr_data == CHAR_LF);
      out_rec_q  <= rec_q;
    end
  end

  assign word_out.valid    = out_valid_q;
  assign word_out.data     = out_data_q;
  assign word_out.last     = out_last_q;
  assign word_out.rec_type = out_rec_q;

endmodule

/* rtl/load_record_parser.sv */
// C and D record parser
`timescale 1ns/1ps

module load_record_parser (
  input  logic        clk,
  input  logic        rst_n,
  word_if.sink        words,
  ram_wr_if.source    wr_req,
  status_ev_if.source events
);
  import ucode_format_pkg::*;
  import diag_bus_pkg::*;

  typedef enum logic [1:0] {WC, ADR, DATA, CKSUM} parse_state_e;

  parse_state_e state_q;
  word16_t      wc_q;
  word16_t      sum_q;
  word16_t      sum_next;
  logic [2:0]   widx_q;
  diag_addr_t   addr_q;
  diag_addr_t   addr_inc;
  cram_addr_t   cram_next_q;
  dram_addr_t   dram_next_q;
  cram_word_t   entry_q;
  cram_word_t   entry_next;
  logic         take;
  logic         is_cram;
  logic         eof_word;
  logic         entry_full;
  logic         entry_done;
  logic         req_valid_q;
  diag_func_e   req_func_q;
  diag_addr_t   req_addr_q;
  diag_data_t   req_data_q;
  logic         good_q, bad_q, eof_c_q, eof_d_q;

  // No new word while a request is still pending
  assign words.ready = ~req_valid_q;
  assign take        = words.valid & words.ready;
  assign is_cram     = (words.rec_type == REC_CRAM);
  assign sum_next    = sum_q + words.data;
  // Count and address both zero ends the file
  assign eof_word    = (wc_q == '0) && (words.data == '0);
  assign addr_inc    = addr_q + (is_cram ? diag_addr_t'(1) : diag_addr_t'(2));
  assign entry_full  = is_cram ? (widx_q == 3'(CRAM_WORDS_PER_ENTRY - 1))
                               : (widx_q == 3'(DRAM_WORDS_PER_PAIR - 1));
  assign entry_done  = take & ~words.last & (state_q == DATA) & entry_full;

  // Drop the current word into its slot
  always_comb begin
    entry_next = entry_q;
    if (is_cram) begin
      case (widx_q)
        3'd0:    entry_next[79:64] = words.data;
        3'd1:    entry_next[63:48] = words.data;
        3'd2:    entry_next[47:32] = words.data;
        3'd3:    entry_next[31:16] = words.data;
        3'd4:    entry_next[15:0]  = words.data;
        default: entry_next[85:80] = words.data[5:0];
      endcase
    end else begin
      // Even, odd, common from high to low
      case (widx_q)
        3'd0:    entry_next[47:32] = words.data;
        3'd1:    entry_next[31:16] = words.data;
        default: entry_next[15:0]  = words.data;
      endcase
    end
  end

  ////////////////////
  // Record FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= WC;
      wc_q        <= '0;
      sum_q       <= '0;
      widx_q      <= '0;
      addr_q      <= '0;
      cram_next_q <= '0;
      dram_next_q <= '0;
    end else if (take) begin
      if (words.last) begin
        // Checksum word closes the line in any state
        state_q <= WC;
        sum_q   <= '0;
      end else begin
        sum_q <= sum_next;
        case (state_q)
          WC: begin
            wc_q    <= words.data;
            state_q <= (words.rec_type == REC_SKIP) ? CKSUM : ADR;
          end
          ADR: begin
            widx_q <= '0;
            if (eof_word) begin
              state_q <= CKSUM;
            end else begin
              state_q <= DATA;
              // Zero address picks up after the last record of this type
              if (words.data != '0)
                addr_q <= is_cram ? diag_addr_t'(cram_addr_t'(words.data))
                                  : diag_addr_t'(dram_addr_t'(words.data));
              else
                addr_q <= is_cram ? diag_addr_t'(cram_next_q)
                                  : diag_addr_t'(dram_next_q);
            end
          end
          DATA: begin
            if (entry_full) begin
              widx_q <= '0;
              addr_q <= addr_inc;
              if (is_cram) cram_next_q <= cram_addr_t'(addr_inc);
              else dram_next_q <= dram_addr_t'(addr_inc);
            end else begin
              widx_q <= widx_q + 3'd1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && !words.last && state_q == DATA) entry_q <= entry_next;
  end

  ////////////////////
  // Write request
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
      req_func_q  <= DF_IDLE;
    end else if (entry_done) begin
      req_valid_q <= 1'b1;
      req_func_q  <= is_cram ? DF_WRITE_CRAM : DF_WRITE_DRAM;
    end else if (wr_req.ready) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (entry_done) begin
      req_addr_q <= addr_q;
      // Dispatch pair sits zero-extended in the low bits
      req_data_q <= is_cram ? diag_data_t'(entry_next)
                            : diag_data_t'(entry_next[DRAM_PAIR_BITS-1:0]);
    end
  end

  assign wr_req.valid = req_valid_q;
  assign wr_req.func  = req_func_q;
  assign wr_req.addr  = req_addr_q;
  assign wr_req.data  = req_data_q;

  // Status pulses, skipped lines stay silent
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      good_q  <= 1'b0;
      bad_q   <= 1'b0;
      eof_c_q <= 1'b0;
      eof_d_q <= 1'b0;
    end else begin
      good_q  <= take & words.last & (words.rec_type != REC_SKIP) & (sum_next == '0);
      bad_q   <= take & words.last & (words.rec_type != REC_SKIP) & (sum_next != '0);
      eof_c_q <= take & ~words.last & (state_q == ADR) & eof_word & is_cram;
      eof_d_q <= take & ~words.last & (state_q == ADR) & eof_word
                 & (words.rec_type == REC_DRAM);
    end
  end

  assign events.line_good = good_q;
  assign events.line_bad  = bad_q;
  assign events.eof_cram  = eof_c_q;
  assign events.eof_dram  = eof_d_q;

endmodule

/* rtl/diag_write_sequencer.sv */
// Diagnostic write strobe sequencer
`timescale 1ns/1ps

module diag_write_sequencer #(
  parameter int STROBE_CYCLES = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  ram_wr_if.sink                   wr_req,
  output diag_bus_pkg::diag_func_e diag_func,
  output logic                     diag_strobe,
  output diag_bus_pkg::diag_addr_t diag_addr,
  output diag_bus_pkg::diag_data_t diag_data
);
  import diag_bus_pkg::*;

  // Enough for strobes up to 15 cycles
  localparam int CNT_BITS = 4;

  typedef enum logic {SQ_IDLE, SQ_STROBE} seq_state_e;

  seq_state_e          state_q;
  logic [CNT_BITS-1:0] left_q;
  diag_func_e          func_q;
  diag_addr_t          addr_q;
  diag_data_t          data_q;
  logic                accept;

  // Low strobe cycle after each write doubles as the accept slot
  assign wr_req.ready = (state_q == SQ_IDLE);
  assign accept       = wr_req.valid & wr_req.ready;

  ////////////////////
  // Strobe timing
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= SQ_IDLE;
      left_q  <= '0;
      func_q  <= DF_IDLE;
    end else if (accept) begin
      state_q <= SQ_STROBE;
      left_q  <= CNT_BITS'(STROBE_CYCLES - 1);
      func_q  <= wr_req.func;
    end else if (state_q == SQ_STROBE) begin
      if (left_q == '0) begin
        // Last strobe cycle, opcode falls back to idle
        state_q <= SQ_IDLE;
        func_q  <= DF_IDLE;
      end else begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  // Address and data held from accept to the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= wr_req.addr;
      data_q <= wr_req.data;
    end
  end

  assign diag_strobe = (state_q == SQ_STROBE);
  assign diag_func   = func_q;
  assign diag_addr   = addr_q;
  assign diag_data   = data_q;

endmodule

/* rtl/loader_status_regs.sv */
// Loader status counters
`timescale 1ns/1ps

module loader_status_regs (
  input  logic        clk,
  input  logic        rst_n,
  status_ev_if.sink   events,
  output logic [15:0] lines_ok,
  output logic [15:0] cksum_errors,
  output logic        cram_done,
  output logic        dram_done
);

  // Stops at all ones
  function automatic logic [15:0] sat_inc(input logic [15:0] v);
    return (v == '1) ? v : v + 16'd1;
  endfunction

  ////////////////////
  // Line counters
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lines_ok     <= '0;
      cksum_errors <= '0;
    end else begin
      if (events.line_good) lines_ok <= sat_inc(lines_ok);
      if (events.line_bad) cksum_errors <= sat_inc(cksum_errors);
    end
  end

  // Sticky end-of-file flags, cleared only by reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cram_done <= 1'b0;
      dram_done <= 1'b0;
    end else begin
      if (events.eof_cram) cram_done <= 1'b1;
      if (events.eof_dram) dram_done <= 1'b1;
    end
  end

endmodule

/* rtl/fe_ucode_loader.sv */
// Front end microcode loader top
`timescale 1ns/1ps

module fe_ucode_loader #(
  parameter int STROBE_CYCLES = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     chr_valid,
  output logic                     chr_ready,
  input  ucode_format_pkg::char_t  chr_data,
  output diag_bus_pkg::diag_func_e diag_func,
  output logic                     diag_strobe,
  output diag_bus_pkg::diag_addr_t diag_addr,
  output diag_bus_pkg::diag_data_t diag_data,
  output logic [15:0]              lines_ok,
  output logic [15:0]              cksum_errors,
  output logic                     cram_done,
  output logic                     dram_done
);

  // Decoder to parser, parser to sequencer, parser to status
  word_if      word_bus ();
  ram_wr_if    wr_bus ();
  status_ev_if ev_bus ();

  asciiz_word_decoder u_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .chr_valid (chr_valid),
    .chr_ready (chr_ready),
    .chr_data  (chr_data),
    .word_out  (word_bus.source)
  );

  load_record_parser u_parser (
    .clk    (clk),
    .rst_n  (rst_n),
    .words  (word_bus.sink),
    .wr_req (wr_bus.source),
    .events (ev_bus.source)
  );

  diag_write_sequencer #(
    .STROBE_CYCLES (STROBE_CYCLES)
  ) u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_req      (wr_bus.sink),
    .diag_func   (diag_func),
    .diag_strobe (diag_strobe),
    .diag_addr   (diag_addr),
    .diag_data   (diag_data)
  );

  loader_status_regs u_status (
    .clk          (clk),
    .rst_n        (rst_n),
    .events       (ev_bus.sink),
    .lines_ok     (lines_ok),
    .cksum_errors (cksum_errors),
    .cram_done    (cram_done),
    .dram_done    (dram_done)
  );

endmodule

/* tests/fe_ucode_loader_checker.sv */
// Loader protocol assertions
`timescale 1ns/1ps

module fe_ucode_loader_checker #(
  parameter int STROBE_CYCLES = 3
) (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     chr_valid,
  input logic                     chr_ready,
  input ucode_format_pkg::char_t  chr_data,
  input diag_bus_pkg::diag_func_e diag_func,
  input logic                     diag_strobe,
  input diag_bus_pkg::diag_addr_t diag_addr,
  input diag_bus_pkg::diag_data_t diag_data
);
  import diag_bus_pkg::*;

  // High cycles of the current strobe seen so far
  int strobe_run_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_run_q <= 0;
    end else if (diag_strobe) begin
      strobe_run_q <= strobe_run_q + 1;
    end else begin
      strobe_run_q <= 0;
    end
  end

  ////////////////////
  // Write port
  ////////////////////

  // Falling edge closes a strobe of full length
  strobe_len_a: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(diag_strobe) |-> strobe_run_q == STROBE_CYCLES)
    else $error("diag_strobe fell after the wrong number of cycles");

  // Never stuck high past its length
  strobe_max_a: assert property (@(posedge clk) disable iff (!rst_n)
    diag_strobe |-> strobe_run_q < STROBE_CYCLES)
    else $error("diag_strobe held longer than its length");

  strobe_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    diag_strobe && $past(diag_strobe)
      |-> $stable(diag_func) && $stable(diag_addr) && $stable(diag_data))
    else $error("write port changed during diag_strobe");

  strobe_func_a: assert property (@(posedge clk) disable iff (!rst_n)
    diag_strobe |-> diag_func != DF_IDLE)
    else $error("diag_func idle during diag_strobe");

  ////////////////////
  // Character input
  ////////////////////

  // Stalled character must wait unchanged
  chr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    chr_valid && !chr_ready |=> chr_valid && $stable(chr_data))
    else $error("chr_data dropped or changed while stalled");

endmodule

bind fe_ucode_loader fe_ucode_loader_checker #(
  .STROBE_CYCLES (STROBE_CYCLES)
) u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .chr_valid   (chr_valid),
  .chr_ready   (chr_ready),
  .chr_data    (chr_data),
  .diag_func   (diag_func),
  .diag_strobe (diag_strobe),
  .diag_addr   (diag_addr),
  .diag_data   (diag_data)
);

/* tests/fe_ucode_loader_tb.sv */
// Microcode loader testbench
`timescale 1ns/1ps

module fe_ucode_loader_tb;
  import ucode_format_pkg::*;
  import diag_bus_pkg::*;

  localparam int STROBE_CYCLES = 3;
  localparam int CLK_NS        = 4;
  // Upper bound on characters sent by all tests
  localparam int TOTAL_CHARS   = 400;
  // One full write slot per character and twice that for margin
  localparam int WATCHDOG_NS   = 2 * TOTAL_CHARS * (STROBE_CYCLES + 1) * CLK_NS;
  localparam int SETTLE_CYCLES = 500;

  // One RAM write as seen on the port
  typedef struct packed {
    diag_func_e func;
    diag_addr_t addr;
    diag_data_t data;
  } wr_rec_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        chr_valid;
  logic        chr_ready;
  char_t       chr_data;
  diag_func_e  diag_func;
  logic        diag_strobe;
  diag_addr_t  diag_addr;
  diag_data_t  diag_data;
  logic [15:0] lines_ok;
  logic [15:0] cksum_errors;
  logic        cram_done;
  logic        dram_done;

  wr_rec_t exp_q[$];
  wr_rec_t got_q[$];
  logic    strobe_seen  = 1'b0;
  bit      gap_mode     = 1'b0;
  // Zero data words sent as empty fields
  bit      empty_fields = 1'b0;
  integer  seed         = 32'h949990d6;
  int      errors       = 0;
  int      checks       = 0;
  int      tests        = 0;
  int      exp_good     = 0;
  int      exp_bad      = 0;
  // Cycles a character waited on chr_ready
  int      stall_cycles = 0;
  // Model of the next free address per RAM
  int      cram_next    = 0;
  int      dram_next    = 0;

  fe_ucode_loader #(
    .STROBE_CYCLES (STROBE_CYCLES)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .chr_valid    (chr_valid),
    .chr_ready    (chr_ready),
    .chr_data     (chr_data),
    .diag_func    (diag_func),
    .diag_strobe  (diag_strobe),
    .diag_addr    (diag_addr),
    .diag_data    (diag_data),
    .lines_ok     (lines_ok),
    .cksum_errors (cksum_errors),
    .cram_done    (cram_done),
    .dram_done    (dram_done)
  );

  initial begin
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the loader stopped making progress", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

  // Record each write on the first strobe cycle
  always @(negedge clk) begin
    if (rst_n && diag_strobe && !strobe_seen) got_q.push_back({diag_func, diag_addr, diag_data});
    strobe_seen = diag_strobe;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error: %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Hold one character until the loader takes it
  task automatic drive_char(input char_t c);
    int r;
    if (gap_mode) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        @(negedge clk);
        chr_valid = 1'b0;
        repeat (r[3:2]) @(negedge clk);
      end
    end
    @(negedge clk);
    chr_valid = 1'b1;
    chr_data  = c;
    while (!chr_ready) begin
      stall_cycles++;
      @(negedge clk);
    end
  endtask

  task automatic release_bus();
    // Last character crosses on the rising edge before this
    @(negedge clk);
    chr_valid = 1'b0;
  endtask

  // Up to three characters of six bits each with bit 6 set
  task automatic encode_word(input word16_t v);
    // Leading zero characters left out on empty-field lines
    if (!empty_fields || v[15:12] != '0) drive_char({3'b100, v[15:12]});
    if (!empty_fields || v[15:6] != '0) drive_char({1'b1, v[11:6]});
    if (!empty_fields || v != '0) drive_char({1'b1, v[5:0]});
  endtask

  task automatic stream_text(input string s);
    int i;
    for (i = 0; i < s.len(); i++) drive_char(char_t'(s[i]));
    release_bus();
  endtask

  // Build a C or D line with random data and queue its writes
  task automatic emit_record(input char_t kind, input int addr, input int entries,
                             input bit corrupt);
    word16_t w[$];
    word16_t sum;
    wr_rec_t rec;
    int      per;
    int      base;
    int      k;
    int      e;
    int      i;
    per  = (kind == CHAR_C) ? CRAM_WORDS_PER_ENTRY : DRAM_WORDS_PER_PAIR;
    // Address 0 resumes after the last record of that RAM
    base = (addr != 0) ? addr : ((kind == CHAR_C) ? cram_next : dram_next);
    w.push_back(word16_t'(per * entries));
    w.push_back(word16_t'(addr));
    for (e = 0; e < entries; e++) begin
      k = w.size();
      for (i = 0; i < per; i++) w.push_back(empty_fields ? '0 : word16_t'($random(seed)));
      rec.addr = diag_addr_t'(base);
      if (kind == CHAR_C) begin
        rec.func = DF_WRITE_CRAM;
        // Sixth word only fills bits 80-85
        rec.data = {w[k+5][5:0], w[k], w[k+1], w[k+2], w[k+3], w[k+4]};
        base     = base + 1;
      end else begin
        rec.func = DF_WRITE_DRAM;
        rec.data = {38'd0, w[k], w[k+1], w[k+2]};
        base     = base + 2;
      end
      exp_q.push_back(rec);
    end
    if (kind == CHAR_C) cram_next = base % 2048;
    else dram_next = base % 512;
    sum = '0;
    foreach (w[j]) sum = sum + w[j];
    // Negated sum with one bit flipped on a broken line
    w.push_back(corrupt ? (word16_t'(-sum) ^ 16'h0100) : word16_t'(-sum));
    if (corrupt) exp_bad++;
    else exp_good++;
    drive_char(kind);
    drive_char(CHAR_SPACE);
    foreach (w[j]) begin
      encode_word(w[j]);
      drive_char((j == w.size() - 1) ? CHAR_LF : CHAR_COMMA);
    end
    release_bus();
  endtask

  // Wait for the expected writes and line results, then compare
  task automatic settle_and_check();
    wr_rec_t ex;
    wr_rec_t ac;
    int      n;
    n = 0;
    while ((got_q.size() < exp_q.size() ||
            int'(lines_ok) + int'(cksum_errors) < exp_good + exp_bad) &&
           n < SETTLE_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (n >= SETTLE_CYCLES) begin
      errors++;
      $display("Timed out after %0d cycles waiting for writes and line counts", n);
    end
    check_val("lines_ok", exp_good, lines_ok);
    check_val("cksum_errors", exp_bad, cksum_errors);
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      ex = exp_q.pop_front();
      ac = got_q.pop_front();
      check_val("diag_func", ex.func, ac.func);
      check_val("diag_addr", ex.addr, ac.addr);
      check_val("diag_data", ex.data, ac.data);
    end
    if (exp_q.size() != got_q.size()) begin
      errors++;
      $display("Write count off: %0d expected writes missing, %0d extra writes seen",
               exp_q.size(), got_q.size());
      exp_q.delete();
      got_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    $display("%s: %s, %0d errors", name, (errors == start_err) ? "ok" : "mismatch",
             errors - start_err);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic cram_single_entry();
    int start;
    start = errors;
    emit_record(CHAR_C, 'o123, 1, 1'b0);
    settle_and_check();
    report_test("cram_single_entry", start);
  endtask

  task automatic dram_two_pairs();
    int start;
    start = errors;
    emit_record(CHAR_D, 'o40, 2, 1'b0);
    settle_and_check();
    report_test("dram_two_pairs", start);
  endtask

  // Writes still go out and only the error count moves
  task automatic bad_checksum_line();
    int start;
    start = errors;
    emit_record(CHAR_C, 'o200, 1, 1'b1);
    settle_and_check();
    report_test("bad_checksum_line", start);
  endtask

  task automatic continue_and_eof();
    int start;
    start = errors;
    emit_record(CHAR_C, 0, 1, 1'b0);
    // Empty count and address fields end the C file
    stream_text("C ,,\n");
    exp_good++;
    settle_and_check();
    check_val("cram_done", 1, cram_done);
    check_val("dram_done", 0, dram_done);
    stream_text("D ,,\n");
    exp_good++;
    settle_and_check();
    check_val("dram_done", 1, dram_done);
    report_test("continue_and_eof", start);
  endtask

  task automatic comment_and_gaps();
    int start;
    start = errors;
    stream_text(";KL10 microcode\n");
    gap_mode = 1'b1;
    emit_record(CHAR_C, 'o400, 2, 1'b0);
    emit_record(CHAR_D, 0, 1, 1'b0);
    emit_record(CHAR_C, 0, 1, 1'b1);
    emit_record(CHAR_D, 'o100, 1, 1'b0);
    stream_text("; trailer\n");
    gap_mode = 1'b0;
    settle_and_check();
    report_test("comment_and_gaps", start);
  endtask

  // Empty fields arrive one per cycle and outrun the write strobe
  task automatic dense_back_pressure();
    int start;
    int stalls_before;
    start         = errors;
    stalls_before = stall_cycles;
    empty_fields  = 1'b1;
    emit_record(CHAR_D, 'o300, 3, 1'b0);
    empty_fields  = 1'b0;
    settle_and_check();
    if (stall_cycles == stalls_before) begin
      errors++;
      $display("chr_ready never dropped while the empty-field line was sent");
    end
    report_test("dense_back_pressure", start);
  endtask

  initial begin
    rst_n     = 1'b0;
    chr_valid = 1'b0;
    chr_data  = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle state after reset
    check_val("chr_ready", 1, chr_ready);
    check_val("diag_strobe", 0, diag_strobe);
    check_val("diag_func", DF_IDLE, diag_func);
    check_val("lines_ok", 0, lines_ok);
    check_val("cksum_errors", 0, cksum_errors);
    check_val("cram_done", 0, cram_done);
    check_val("dram_done", 0, dram_done);
    cram_single_entry();
    dram_two_pairs();
    bad_checksum_line();
    continue_and_eof();
    comment_and_gaps();
    dense_back_pressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* fe_ucode_loader.f */
rtl/ucode_format_pkg.sv
rtl/diag_bus_pkg.sv
rtl/fe_loader_ifs.sv
rtl/asciiz_word_decoder.sv
rtl/load_record_parser.sv
rtl/diag_write_sequencer.sv
rtl/loader_status_regs.sv
rtl/fe_ucode_loader.sv
tests/fe_ucode_loader_checker.sv
tests/fe_ucode_loader_tb.sv

/* Makefile */
# Verilator build and run for the microcode loader

VERILATOR ?= verilator
TOP       ?= fe_ucode_loader_tb
RTL_TOP   ?= fe_ucode_loader
FILELIST  ?= fe_ucode_loader.f
SEED      ?= 1
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Output goes to the console, status comes from the search
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
